// File: hdl/isaPkg.sv
package isaPkg;

    parameter int WORD_WIDTH   = 32;  // Data and address width
    parameter int IMM_WIDTH    = 12;
    parameter int INDEX_WIDTH  = 4;   // Register index width
    parameter int OPCODE_WIDTH = 4;
    parameter int DEREF_WIDTH  = 2;

    parameter logic [INDEX_WIDTH-1:0] ZERO_REG = 4'd0;   // Always reads zero
    parameter logic [INDEX_WIDTH-1:0] PC_REG   = 4'd15;  // Program counter alias

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OR     = 4'h0,
        AND    = 4'h1,
        ADD    = 4'h2,
        MUL    = 4'h3,
        RSVD4  = 4'h4,
        SHL    = 4'h5,
        CMPLT  = 4'h6,
        CMPEQ  = 4'h7,
        CMPGT  = 4'h8,
        ANDN   = 4'h9,  // X and not operand
        XOR    = 4'hA,
        SUB    = 4'hB,
        XNOR   = 4'hC,
        SHR    = 4'hD,  // Logical shift
        CMPNE  = 4'hE,
        RSVD15 = 4'hF
    } opcode_e;

    typedef enum logic [DEREF_WIDTH-1:0] {
        REG_WRITE       = 2'd0,  // Z <- result
        LOAD            = 2'd1,  // Z <- mem[result]
        STORE_AT_Z      = 2'd2,  // mem[Z] <- result
        STORE_AT_RESULT = 2'd3   // mem[result] <- Z
    } deref_e;

endpackage

// File: hdl/corePkg.sv
package corePkg;

    // One instruction walks through these three phases in order
    typedef enum logic [1:0] {
        DECODE    = 2'd0,
        EXECUTE   = 2'd1,
        WRITEBACK = 2'd2
    } phase_e;

    parameter logic [isaPkg::WORD_WIDTH-1:0] DEFAULT_RESET_VECTOR = 32'h0000_0000;

endpackage

// File: hdl/instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder (
    input  logic [isaPkg::WORD_WIDTH-1:0]  iData,
    output logic [isaPkg::INDEX_WIDTH-1:0] indexZ,
    output logic [isaPkg::INDEX_WIDTH-1:0] indexX,
    output logic [isaPkg::INDEX_WIDTH-1:0] indexY,
    output logic [isaPkg::IMM_WIDTH-1:0]   immediate,
    output isaPkg::opcode_e                opcode,
    output isaPkg::deref_e                 derefMode,
    output logic                           format,
    output logic                           illegal
);

    // Bit 31 only matters for the illegal check
    assign format    = iData[30];
    assign derefMode = isaPkg::deref_e'(iData[28 +: isaPkg::DEREF_WIDTH]);
    assign indexZ    = iData[24 +: isaPkg::INDEX_WIDTH];
    assign indexX    = iData[20 +: isaPkg::INDEX_WIDTH];
    assign indexY    = iData[16 +: isaPkg::INDEX_WIDTH];
    assign opcode    = isaPkg::opcode_e'(iData[12 +: isaPkg::OPCODE_WIDTH]);
    assign immediate = iData[0 +: isaPkg::IMM_WIDTH];

    assign illegal   = &iData;  // All ones halts the core

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           enable,
    input  logic                           writeEnable,
    input  logic [isaPkg::INDEX_WIDTH-1:0] indexZ,
    input  logic [isaPkg::INDEX_WIDTH-1:0] indexX,
    input  logic [isaPkg::INDEX_WIDTH-1:0] indexY,
    input  logic [isaPkg::WORD_WIDTH-1:0]  writeData,
    input  logic [isaPkg::WORD_WIDTH-1:0]  pcValue,
    output logic [isaPkg::WORD_WIDTH-1:0]  valueZ,
    output logic [isaPkg::WORD_WIDTH-1:0]  valueX,
    output logic [isaPkg::WORD_WIDTH-1:0]  valueY
);

    logic [isaPkg::WORD_WIDTH-1:0] regs [1:14];  // Only the general registers
    logic [isaPkg::WORD_WIDTH-1:0] pcNext;

    assign pcNext = pcValue + 1;  // PC reads as next instruction address

    assign valueZ = (indexZ == isaPkg::ZERO_REG) ? '0 :
                    (indexZ == isaPkg::PC_REG)   ? pcNext : regs[indexZ];
    assign valueX = (indexX == isaPkg::ZERO_REG) ? '0 :
                    (indexX == isaPkg::PC_REG)   ? pcNext : regs[indexX];
    assign valueY = (indexY == isaPkg::ZERO_REG) ? '0 :
                    (indexY == isaPkg::PC_REG)   ? pcNext : regs[indexY];

    // writeEnable never arrives for index 0 or 15
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (enable && writeEnable) begin
            regs[indexZ] <= writeData;
        end
    end

endmodule

// File: hdl/executeUnit.sv
`timescale 1ns/10ps

module executeUnit (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          execEnable,
    input  logic                          format,
    input  isaPkg::opcode_e               opcode,
    input  logic [isaPkg::WORD_WIDTH-1:0] valueX,
    input  logic [isaPkg::WORD_WIDTH-1:0] valueY,
    input  logic [isaPkg::IMM_WIDTH-1:0]  immediate,
    output logic [isaPkg::WORD_WIDTH-1:0] result
);

    localparam int W = isaPkg::WORD_WIDTH;

    logic [W-1:0] immExt;
    logic [W-1:0] operand;
    logic [W-1:0] addend;
    logic [W-1:0] opResult;

    assign immExt  = {{(W - isaPkg::IMM_WIDTH){immediate[isaPkg::IMM_WIDTH-1]}}, immediate};
    assign operand = format ? immExt : valueY;  // Format 1 swaps Y and immediate
    assign addend  = format ? valueY : immExt;

    always_comb begin
        case (opcode)
            isaPkg::OR:    opResult = valueX | operand;
            isaPkg::AND:   opResult = valueX & operand;
            isaPkg::ADD:   opResult = valueX + operand;
            isaPkg::MUL:   opResult = valueX * operand;
            isaPkg::SHL:   opResult = valueX << operand;
            isaPkg::CMPLT: opResult = {W{$signed(valueX) < $signed(operand)}};
            isaPkg::CMPEQ: opResult = {W{valueX == operand}};
            isaPkg::CMPGT: opResult = {W{$signed(valueX) > $signed(operand)}};
            isaPkg::ANDN:  opResult = valueX & ~operand;
            isaPkg::XOR:   opResult = valueX ^ operand;
            isaPkg::SUB:   opResult = valueX - operand;
            isaPkg::XNOR:  opResult = valueX ~^ operand;
            isaPkg::SHR:   opResult = valueX >> operand;
            isaPkg::CMPNE: opResult = {W{valueX != operand}};
            default:       opResult = '0;  // Reserved opcodes leave only the addend
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result <= '0;
        end else if (execEnable) begin
            result <= opResult + addend;  // Held through writeback
        end
    end

endmodule

// File: hdl/memoryRouter.sv
`timescale 1ns/10ps

module memoryRouter (
    input  logic                          memEnable,
    input  isaPkg::deref_e                derefMode,
    input  logic [isaPkg::WORD_WIDTH-1:0] result,
    input  logic [isaPkg::WORD_WIDTH-1:0] valueZ,
    input  logic [isaPkg::WORD_WIDTH-1:0] dReadData,
    output logic [isaPkg::WORD_WIDTH-1:0] dAddr,
    output logic [isaPkg::WORD_WIDTH-1:0] dWriteData,
    output logic                          dWrite,
    output logic [isaPkg::WORD_WIDTH-1:0] writeValue,
    output logic                          writesRegister
);

    logic isStore;

    assign isStore = (derefMode == isaPkg::STORE_AT_Z) ||
                     (derefMode == isaPkg::STORE_AT_RESULT);

    // Z is the address only when storing at Z, else the result is
    assign dAddr      = (derefMode == isaPkg::STORE_AT_Z) ? valueZ : result;
    assign dWriteData = (derefMode == isaPkg::STORE_AT_Z) ? result : valueZ;
    assign dWrite     = memEnable && isStore;

    assign writeValue     = (derefMode == isaPkg::LOAD) ? dReadData : result;
    assign writesRegister = !isStore;  // REG_WRITE and LOAD

endmodule

// File: hdl/cycleSequencer.sv
`timescale 1ns/10ps

module cycleSequencer #(
    parameter logic [isaPkg::WORD_WIDTH-1:0] resetVector = corePkg::DEFAULT_RESET_VECTOR
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           enable,
    input  logic                           illegal,
    input  logic [isaPkg::INDEX_WIDTH-1:0] indexZ,
    input  logic                           writesRegister,
    input  logic [isaPkg::WORD_WIDTH-1:0]  writeValue,
    output logic [isaPkg::WORD_WIDTH-1:0]  iAddr,
    output logic                           halted,
    output logic                           execEnable,
    output logic                           memEnable,
    output logic                           regWriteEnable
);

    corePkg::phase_e phase;
    logic            jumping;

    assign jumping = writesRegister && (indexZ == isaPkg::PC_REG);

    assign execEnable = enable && !halted && (phase == corePkg::EXECUTE);
    assign memEnable  = (phase == corePkg::WRITEBACK);  // Qualifies dWrite

    // Z of 0 drops the write, Z of 15 goes to the program counter instead
    assign regWriteEnable = memEnable && writesRegister &&
                            (indexZ != isaPkg::ZERO_REG) &&
                            (indexZ != isaPkg::PC_REG);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase  <= corePkg::DECODE;
            iAddr  <= resetVector;
            halted <= 1'b0;
        end else if (enable && !halted) begin
            case (phase)
                corePkg::DECODE: begin
                    if (illegal) begin
                        halted <= 1'b1;  // Stays in DECODE until reset
                    end else begin
                        phase <= corePkg::EXECUTE;
                    end
                end
                corePkg::EXECUTE: phase <= corePkg::WRITEBACK;
                corePkg::WRITEBACK: begin
                    phase <= corePkg::DECODE;
                    iAddr <= jumping ? writeValue : iAddr + 1;
                end
                default: phase <= corePkg::DECODE;
            endcase
        end
    end

endmodule

// File: hdl/tenyrCore.sv
`timescale 1ns/10ps

module tenyrCore #(
    parameter logic [isaPkg::WORD_WIDTH-1:0] resetVector = corePkg::DEFAULT_RESET_VECTOR
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          enable,
    output logic [isaPkg::WORD_WIDTH-1:0] iAddr,
    input  logic [isaPkg::WORD_WIDTH-1:0] iData,
    output logic [isaPkg::WORD_WIDTH-1:0] dAddr,
    output logic [isaPkg::WORD_WIDTH-1:0] dWriteData,
    output logic                          dWrite,
    input  logic [isaPkg::WORD_WIDTH-1:0] dReadData,
    output logic                          halted
);

    logic [isaPkg::INDEX_WIDTH-1:0] indexZ;
    logic [isaPkg::INDEX_WIDTH-1:0] indexX;
    logic [isaPkg::INDEX_WIDTH-1:0] indexY;
    logic [isaPkg::IMM_WIDTH-1:0]   immediate;
    isaPkg::opcode_e                opcode;
    isaPkg::deref_e                 derefMode;
    logic                           format;
    logic                           illegal;
    logic [isaPkg::WORD_WIDTH-1:0]  valueZ;
    logic [isaPkg::WORD_WIDTH-1:0]  valueX;
    logic [isaPkg::WORD_WIDTH-1:0]  valueY;
    logic [isaPkg::WORD_WIDTH-1:0]  result;
    logic [isaPkg::WORD_WIDTH-1:0]  writeValue;
    logic                           writesRegister;
    logic                           execEnable;
    logic                           memEnable;
    logic                           regWriteEnable;

    instructionDecoder i_instructionDecoder (
        .iData(iData), .indexZ(indexZ), .indexX(indexX), .indexY(indexY),
        .immediate(immediate), .opcode(opcode), .derefMode(derefMode),
        .format(format), .illegal(illegal)
    );

    registerFile i_registerFile (
        .clk(clk), .reset_n(reset_n), .enable(enable), .writeEnable(regWriteEnable),
        .indexZ(indexZ), .indexX(indexX), .indexY(indexY), .writeData(writeValue),
        .pcValue(iAddr), .valueZ(valueZ), .valueX(valueX), .valueY(valueY)
    );

    executeUnit i_executeUnit (
        .clk(clk), .reset_n(reset_n), .execEnable(execEnable), .format(format),
        .opcode(opcode), .valueX(valueX), .valueY(valueY), .immediate(immediate),
        .result(result)
    );

    memoryRouter i_memoryRouter (
        .memEnable(memEnable), .derefMode(derefMode), .result(result), .valueZ(valueZ),
        .dReadData(dReadData), .dAddr(dAddr), .dWriteData(dWriteData), .dWrite(dWrite),
        .writeValue(writeValue), .writesRegister(writesRegister)
    );

    cycleSequencer #(.resetVector(resetVector)) i_cycleSequencer (
        .clk(clk), .reset_n(reset_n), .enable(enable), .illegal(illegal),
        .indexZ(indexZ), .writesRegister(writesRegister), .writeValue(writeValue),
        .iAddr(iAddr), .halted(halted), .execEnable(execEnable),
        .memEnable(memEnable), .regWriteEnable(regWriteEnable)
    );

endmodule

// File: testbench/tenyrCore_props.sv
`timescale 1ns/10ps

module tenyrCore_props (
    input logic                          clk,
    input logic                          reset_n,
    input logic [isaPkg::WORD_WIDTH-1:0] iAddr,
    input logic                          dWrite,
    input logic                          halted
);

    // A new fetch address is held through execute and writeback
    property addrHold;
        @(posedge clk) disable iff (!reset_n)
            !$stable(iAddr) |=> $stable(iAddr) ##1 $stable(iAddr);
    endproperty

    property noWriteWhenHalted;
        @(posedge clk) disable iff (!reset_n) halted |-> !dWrite;
    endproperty

    property haltSticky;
        @(posedge clk) disable iff (!reset_n) halted |=> halted;
    endproperty

    // Checked one edge late so the first reset edge has settled the state
    property quietInReset;
        @(posedge clk) !reset_n |=> !dWrite;
    endproperty

    assert property (addrHold) else $error("iAddr changed twice within one instruction");
    assert property (noWriteWhenHalted) else $error("dWrite high while halted");
    assert property (haltSticky) else $error("halted dropped without a reset");
    assert property (quietInReset) else $error("dWrite high during reset");

endmodule

bind tenyrCore tenyrCore_props i_tenyrCore_props (
    .clk(clk),
    .reset_n(reset_n),
    .iAddr(iAddr),
    .dWrite(dWrite),
    .halted(halted)
);

// File: testbench/coreTb.sv
`timescale 1ns/10ps

module coreTb;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 10;
    localparam int STALL_CYCLES = 5;
    localparam int HALT_CYCLES  = 8;
    localparam int PROG_LEN     = 47;
    localparam int STALL_ADDR   = 8;   // First random store

    logic        clk;
    logic        reset_n;
    logic        enable;
    logic [31:0] iAddr;
    logic [31:0] iData;
    logic [31:0] dAddr;
    logic [31:0] dWriteData;
    logic        dWrite;
    logic [31:0] dReadData;
    logic        halted;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] refMem [0:63];   // Reference model state
    logic [31:0] refRegs [0:15];
    logic [31:0] refPc;
    logic [31:0] expAddr;
    logic [31:0] expData;
    logic [31:0] expValue;
    logic [31:0] expNext;
    logic [3:0]  expZ;
    logic        expStore;
    logic        expWrite;
    logic        expHalt;
    logic        storeSeen;
    logic        running;
    logic [31:0] frozenAddr;
    logic        frozenWrite;
    integer      seed;

    tenyrCore #(.resetVector(RESET_VECTOR)) i_tenyrCore (
        .clk(clk), .reset_n(reset_n), .enable(enable), .iAddr(iAddr), .iData(iData),
        .dAddr(dAddr), .dWriteData(dWriteData), .dWrite(dWrite), .dReadData(dReadData),
        .halted(halted)
    );

    assign iData     = imem[iAddr[5:0]];
    assign dReadData = dmem[dAddr[5:0]];  // Combinational read

    function automatic logic [31:0] fillWord(input int addr);
        return 32'hDA7A_0000 ^ (addr * 32'h0001_0103);
    endfunction

    always @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dWrite) begin
            dmem[dAddr[5:0]] <= dWriteData;
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] encodeInstr(input logic fmt, input logic [1:0] mode,
            input logic [3:0] z, input logic [3:0] x, input logic [3:0] y,
            input logic [3:0] op, input logic [11:0] imm);
        return {1'b0, fmt, mode, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] refAlu(input logic [3:0] op, input logic [31:0] a,
            input logic [31:0] b);
        case (op)
            isaPkg::OR:    return a | b;
            isaPkg::AND:   return a & b;
            isaPkg::ADD:   return a + b;
            isaPkg::MUL:   return a * b;
            isaPkg::SHL:   return a << b;
            isaPkg::CMPLT: return ($signed(a) < $signed(b)) ? 32'hFFFF_FFFF : 32'h0;
            isaPkg::CMPEQ: return (a == b) ? 32'hFFFF_FFFF : 32'h0;
            isaPkg::CMPGT: return ($signed(a) > $signed(b)) ? 32'hFFFF_FFFF : 32'h0;
            isaPkg::ANDN:  return a & ~b;
            isaPkg::XOR:   return a ^ b;
            isaPkg::SUB:   return a - b;
            isaPkg::XNOR:  return ~(a ^ b);
            isaPkg::SHR:   return a >> b;
            isaPkg::CMPNE: return (a != b) ? 32'hFFFF_FFFF : 32'h0;
            default:       return 32'h0;  // Reserved
        endcase
    endfunction

    function automatic logic [31:0] readReg(input logic [3:0] idx);
        if (idx == isaPkg::ZERO_REG) begin
            return 32'h0;
        end
        if (idx == isaPkg::PC_REG) begin
            return refPc + 32'd1;
        end
        return refRegs[idx];
    endfunction

    // Expected effects of the instruction at refPc
    task automatic predictStep();
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] res;
        w   = imem[refPc[5:0]];
        imm = {{20{w[11]}}, w[11:0]};
        x   = readReg(w[23:20]);
        y   = readReg(w[19:16]);
        res = w[30] ? refAlu(w[15:12], x, imm) + y : refAlu(w[15:12], x, y) + imm;
        expHalt  = (w == 32'hFFFF_FFFF);
        expZ     = w[27:24];
        expStore = (w[29:28] == isaPkg::STORE_AT_Z) || (w[29:28] == isaPkg::STORE_AT_RESULT);
        expWrite = !expStore;
        expAddr  = (w[29:28] == isaPkg::STORE_AT_Z) ? readReg(expZ) : res;
        expData  = (w[29:28] == isaPkg::STORE_AT_Z) ? res : readReg(expZ);
        expValue = (w[29:28] == isaPkg::LOAD) ? refMem[res[5:0]] : res;
        expNext  = (expWrite && expZ == isaPkg::PC_REG) ? expValue : refPc + 32'd1;
        storeSeen = 1'b0;
    endtask

    task automatic commitStep();
        assert (!expHalt) else failRun("Illegal instruction did not halt the core");
        assert (iAddr == expNext) else
            failRun($sformatf("Mismatch at %0t: iAddr %h, expected %h", $time, iAddr, expNext));
        assert (storeSeen == expStore) else
            failRun($sformatf("No store seen for the instruction at %h", refPc));
        if (expStore) begin
            refMem[expAddr[5:0]] = expData;
        end
        if (expWrite && expZ != isaPkg::ZERO_REG && expZ != isaPkg::PC_REG) begin
            refRegs[expZ] = expValue;
        end
        refPc = iAddr;
        predictStep();
    endtask

    task automatic loadProgram();
        int pc;
        for (int i = 0; i < 64; i++) begin
            imem[i] = encodeInstr(1'b0, isaPkg::REG_WRITE, 4'd0, 4'd0, 4'd0, isaPkg::OR, 12'(i));
        end
        imem[0] = encodeInstr(1'b0, isaPkg::REG_WRITE, 4'd1, 4'd0, 4'd0, isaPkg::OR, 12'h123);
        imem[1] = encodeInstr(1'b0, isaPkg::REG_WRITE, 4'd2, 4'd0, 4'd0, isaPkg::OR, 12'hFFB);
        imem[2] = encodeInstr(1'b1, isaPkg::REG_WRITE, 4'd3, 4'd1, 4'd0, isaPkg::MUL, 12'h7FF);
        imem[3] = encodeInstr(1'b0, isaPkg::REG_WRITE, 4'd4, 4'd2, 4'd2, isaPkg::ADD, 12'h000);
        imem[4] = encodeInstr(1'b0, isaPkg::REG_WRITE, 4'd13, 4'd0, 4'd0, isaPkg::OR, 12'd48);
        imem[5] = encodeInstr(1'b0, isaPkg::REG_WRITE, 4'd0, 4'd1, 4'd0, isaPkg::OR, 12'h055);
        imem[6] = encodeInstr(1'b0, isaPkg::STORE_AT_RESULT, 4'd0, 4'd0, 4'd0, isaPkg::OR, 12'd50);
        imem[7] = encodeInstr(1'b0, isaPkg::STORE_AT_Z, 4'd13, 4'd15, 4'd0, isaPkg::OR, 12'h0);
        pc = 8;
        for (int f = 0; f < 2; f++) begin
            for (int op = 0; op < 16; op++) begin
                imem[pc] = encodeInstr(f[0], isaPkg::STORE_AT_Z, 4'd13, 4'($random(seed)),
                                       4'($random(seed)), op[3:0], 12'($random(seed)));
                pc++;
            end
        end
        imem[40] = encodeInstr(1'b0, isaPkg::LOAD, 4'd5, 4'd0, 4'd0, isaPkg::OR, 12'd20);
        imem[41] = encodeInstr(1'b0, isaPkg::STORE_AT_RESULT, 4'd5, 4'd0, 4'd0, isaPkg::OR, 12'd51);
        imem[42] = encodeInstr(1'b0, isaPkg::REG_WRITE, 4'd15, 4'd15, 4'd0, isaPkg::OR, 12'd2);
        imem[43] = encodeInstr(1'b0, isaPkg::STORE_AT_Z, 4'd13, 4'd0, 4'd0, isaPkg::OR, 12'hBAD);
        imem[44] = encodeInstr(1'b0, isaPkg::STORE_AT_Z, 4'd13, 4'd0, 4'd0, isaPkg::OR, 12'hBAD);
        imem[45] = encodeInstr(1'b0, isaPkg::STORE_AT_RESULT, 4'd1, 4'd0, 4'd0, isaPkg::OR, 12'd52);
        imem[46] = 32'hFFFF_FFFF;  // Illegal word ends the program
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((PROG_LEN * 3 + RESET_CYCLES + STALL_CYCLES + HALT_CYCLES) * PERIOD + 200);
        failRun("Timeout: the core did not reach the halt in time");
    end

    // Outputs settle after the rising edge, so compare on the falling one
    initial begin
        wait (running);
        forever begin
            @(negedge clk);
            if (dWrite) begin
                assert (expStore && dAddr == expAddr && dWriteData == expData) else
                    failRun($sformatf("Mismatch at %0t: store %h <- %h, expected %h <- %h",
                                      $time, dAddr, dWriteData, expAddr, expData));
                storeSeen = 1'b1;
            end
            if (halted) begin
                assert (expHalt) else failRun("Core halted on a legal instruction");
            end
            if (iAddr != refPc) begin
                commitStep();
            end
        end
    end

    initial begin
        seed    = 32'h157d;
        reset_n = 1'b0;
        enable  = 1'b1;
        running = 1'b0;
        loadProgram();
        for (int i = 0; i < 64; i++) begin
            refMem[i] = fillWord(i);
        end
        for (int i = 0; i < 16; i++) begin
            refRegs[i] = 32'h0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        assert (iAddr == RESET_VECTOR && !dWrite && !halted) else
            failRun($sformatf("Mismatch at %0t: reset state iAddr %h dWrite %b halted %b",
                              $time, iAddr, dWrite, halted));
        reset_n = 1'b1;
        refPc   = RESET_VECTOR;
        predictStep();
        running = 1'b1;

        while (iAddr != STALL_ADDR) @(negedge clk);
        repeat (2) @(negedge clk);  // Now in writeback
        enable      = 1'b0;
        frozenAddr  = iAddr;
        frozenWrite = dWrite;
        assert (frozenWrite) else failRun("Stall did not land in a store writeback");
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            assert (iAddr == frozenAddr && dWrite == frozenWrite) else
                failRun($sformatf("Mismatch at %0t: core moved while stalled", $time));
        end
        enable = 1'b1;

        while (!halted) @(negedge clk);
        frozenAddr = iAddr;
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            assert (iAddr == frozenAddr && !dWrite) else
                failRun($sformatf("Mismatch at %0t: core active after halt", $time));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: all.f
hdl/isaPkg.sv
hdl/corePkg.sv
hdl/instructionDecoder.sv
hdl/registerFile.sv
hdl/executeUnit.sv
hdl/memoryRouter.sv
hdl/cycleSequencer.sv
hdl/tenyrCore.sv
testbench/tenyrCore_props.sv
testbench/coreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module coreTb -o coreSim \
    && ./obj_dir/coreSim | tee /dev/stderr | grep -F "ALL TESTS PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
